/* ex_defines.svh */
/*
 * Execute stage sizing constants
 * Data width, register index width and the multiplier step split
 */

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data path width
`define EX_XLEN 32

// Register file index width
`define EX_RF_ADDR_W 5

// Accumulate steps per multiply
`define EX_MUL_STEPS 4

// Bits of operand B consumed in one step
`define EX_MUL_CHUNK (`EX_XLEN / `EX_MUL_STEPS)

`endif

/* ex_pkg.sv */
/*
 * Execute stage types
 * Operator encodings and the pipeline structs around EX
 */

`default_nettype none

`include "ex_defines.svh"

package ex_pkg;

  // Basic words
  typedef logic [`EX_XLEN-1:0]      xlen_t;
  typedef logic [`EX_RF_ADDR_W-1:0] rf_addr_t;

  // ALU operators, comparisons in the upper half
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  // Multiply flavour; signed mode picks MULH, MULHSU or MULHU
  typedef enum logic [1:0] {
    MUL_M32 = 2'b00,
    MUL_H   = 2'b11
  } mul_op_e;

  // Instruction as handed over by decode
  typedef struct packed {
    logic       instr_valid;
    xlen_t      pc;
    logic       alu_en;
    alu_op_e    alu_op;
    xlen_t      alu_operand_a;
    xlen_t      alu_operand_b;
    // Branch target
    xlen_t      operand_c;
    logic       alu_bch;
    logic       alu_jmp;
    logic       mul_en;
    mul_op_e    mul_op;
    // Bit 1 marks A signed, bit 0 marks B signed
    logic [1:0] mul_signed_mode;
    xlen_t      muldiv_operand_a;
    xlen_t      muldiv_operand_b;
    logic       rf_we;
    rf_addr_t   rf_waddr;
    logic       illegal_insn;
  } id_ex_pipe_t;

  // Controller commands to EX
  typedef struct packed {
    logic halt_ex;
    logic kill_ex;
  } ctrl_ex_t;

  // ALU output
  typedef struct packed {
    xlen_t result;
    logic  cmp_result;
  } alu_res_t;

  // EX/WB pipeline register
  typedef struct packed {
    logic     instr_valid;
    xlen_t    pc;
    logic     rf_we;
    rf_addr_t rf_waddr;
    xlen_t    rf_wdata;
    logic     illegal_insn;
    logic     alu_jmp_qual;
    logic     alu_bch_qual;
    logic     alu_bch_taken_qual;
  } ex_wb_pipe_t;

endpackage

`default_nettype wire

/* ex_alu.sv */
/*
 * Integer ALU
 * Single-cycle add, subtract, logic, shifts, set-less-than and branch compares
 */

`default_nettype none

`include "ex_defines.svh"

module ex_alu import ex_pkg::*; (
  input  alu_op_e  alu_op_i,
  input  xlen_t    operand_a_i,
  input  xlen_t    operand_b_i,
  output alu_res_t res_o
);

  localparam int unsigned SHAMT_W = $clog2(`EX_XLEN);

  logic [SHAMT_W-1:0] shamt;
  xlen_t              sum;
  xlen_t              diff;
  logic               is_equal;
  logic               lt_signed;
  logic               lt_unsigned;
  logic               cmp;

  //////////////////////////////////////////////////
  // Shared arithmetic
  //////////////////////////////////////////////////

  // Only the low bits of B shift
  assign shamt = operand_b_i[SHAMT_W-1:0];

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Comparators shared by SLT and branches
  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  //////////////////////////////////////////////////
  // Comparison flag
  //////////////////////////////////////////////////

  always_comb begin
    unique case (alu_op_i)
      ALU_EQ:           cmp = is_equal;
      ALU_NE:           cmp = !is_equal;
      ALU_SLT, ALU_LT:  cmp = lt_signed;
      ALU_GE:           cmp = !lt_signed;
      ALU_SLTU, ALU_LTU: cmp = lt_unsigned;
      ALU_GEU:          cmp = !lt_unsigned;
      // Non-compare operators never take a branch
      default:          cmp = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb begin
    unique case (alu_op_i)
      ALU_ADD: res_o.result = sum;
      ALU_SUB: res_o.result = diff;
      ALU_AND: res_o.result = operand_a_i & operand_b_i;
      ALU_OR:  res_o.result = operand_a_i | operand_b_i;
      ALU_XOR: res_o.result = operand_a_i ^ operand_b_i;
      ALU_SLL: res_o.result = operand_a_i << shamt;
      ALU_SRL: res_o.result = operand_a_i >> shamt;
      ALU_SRA: res_o.result = $signed(operand_a_i) >>> shamt;
      // SLT, SLTU and branch compares land in bit 0
      default: res_o.result = xlen_t'(cmp);
    endcase
  end

  // Branch decision flag
  assign res_o.cmp_result = cmp;

endmodule

`default_nettype wire

/* ex_mult.sv */
/*
 * Iterative multiplier
 * MUL, MULH, MULHSU and MULHU as a fixed number of accumulate steps
 * Supports halt, kill and a valid/ready result hold
 */

`default_nettype none

`include "ex_defines.svh"

module ex_mult import ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  mul_op_e    mul_op_i,
  input  logic [1:0] signed_mode_i,
  input  xlen_t      op_a_i,
  input  xlen_t      op_b_i,
  input  logic       halt_i,
  input  logic       kill_i,
  input  logic       valid_i,
  input  logic       ready_i,
  output logic       valid_o,
  output logic       ready_o,
  output xlen_t      result_o
);

  localparam int unsigned XLEN  = `EX_XLEN;
  localparam int unsigned STEPS = `EX_MUL_STEPS;
  localparam int unsigned CHUNK = `EX_MUL_CHUNK;
  localparam int unsigned CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;
  // 33-bit A times 9-bit slice
  localparam int unsigned PP_W  = XLEN + CHUNK + 2;
  // Full 33x33 signed product
  localparam int unsigned ACC_W = 2 * XLEN + 2;

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_STEP,
    MUL_DONE
  } mul_state_e;

  mul_state_e             state_q;
  mul_state_e             state_d;
  logic [CNT_W-1:0]       cnt_q;
  logic [CNT_W-1:0]       cnt_d;
  logic [CNT_W-1:0]       cur_step;
  logic [XLEN:0]          a_ext;
  logic                   b_sign;
  logic [CHUNK-1:0]       b_slice;
  logic [CHUNK:0]         b_chunk;
  logic signed [PP_W-1:0] pp;
  logic [ACC_W-1:0]       pp_ext;
  logic [ACC_W-1:0]       pp_shifted;
  logic [ACC_W-1:0]       acc_base;
  logic [ACC_W-1:0]       acc_d;
  logic [ACC_W-1:0]       acc_q;
  logic                   acc_en;

  //////////////////////////////////////////////////
  // Partial product datapath
  //////////////////////////////////////////////////

  // Idle computes step 0 from an empty accumulator
  assign cur_step = (state_q == MUL_IDLE) ? '0 : cnt_q;
  assign acc_base = (state_q == MUL_IDLE) ? '0 : acc_q;

  // Sign or zero extend A to 33 bits
  assign a_ext  = {signed_mode_i[1] & op_a_i[XLEN-1], op_a_i};
  assign b_sign = signed_mode_i[0] & op_b_i[XLEN-1];

  // Slice of B for this step; top slice carries the sign of B
  assign b_slice = op_b_i[cur_step*CHUNK +: CHUNK];
  assign b_chunk = {(cur_step == CNT_W'(STEPS-1)) & b_sign, b_slice};

  assign pp         = $signed(a_ext) * $signed(b_chunk);
  assign pp_ext     = {{(ACC_W-PP_W){pp[PP_W-1]}}, pp};
  assign pp_shifted = pp_ext << (cur_step * CHUNK);
  assign acc_d      = acc_base + pp_shifted;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    acc_en  = 1'b0;
    if (kill_i) begin
      // Drop any multiply in flight
      state_d = MUL_IDLE;
      cnt_d   = '0;
    end else if (!halt_i) begin
      unique case (state_q)
        MUL_IDLE: begin
          if (valid_i) begin
            acc_en  = 1'b1;
            cnt_d   = CNT_W'(1);
            state_d = (STEPS == 1) ? MUL_DONE : MUL_STEP;
          end
        end
        MUL_STEP: begin
          acc_en = 1'b1;
          cnt_d  = cnt_q + 1'b1;
          if (cnt_q == CNT_W'(STEPS-1)) begin
            state_d = MUL_DONE;
          end
        end
        MUL_DONE: begin
          // Hold result until write-back takes it
          if (ready_i) begin
            state_d = MUL_IDLE;
            cnt_d   = '0;
          end
        end
        default: state_d = MUL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Product accumulator
  always_ff @(posedge clk) begin
    if (acc_en) begin
      acc_q <= acc_d;
    end
  end

  //////////////////////////////////////////////////
  // Handshake and result
  //////////////////////////////////////////////////

  assign valid_o = (state_q == MUL_DONE);
  assign ready_o = ((state_q == MUL_IDLE) && !valid_i) || (valid_o && ready_i);

  // Low word for MUL, high word for the MULH flavours
  assign result_o = (mul_op_i == MUL_H) ? acc_q[2*XLEN-1:XLEN] : acc_q[XLEN-1:0];

endmodule

`default_nettype wire

/* ex_wb_combine.sv */
/*
 * EX result combiner
 * Write-back data select, stage valid/ready and the EX/WB register
 */

`default_nettype none

module ex_wb_combine import ex_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  id_ex_pipe_t id_ex_i,
  input  ctrl_ex_t    ctrl_i,
  input  alu_res_t    alu_res_i,
  input  xlen_t       mul_result_i,
  input  logic        mul_valid_i,
  input  logic        mul_ready_i,
  input  logic        wb_ready_i,
  output xlen_t       rf_wdata_o,
  output logic        branch_decision_o,
  output logic        ex_valid_o,
  output logic        ex_ready_o,
  output ex_wb_pipe_t ex_wb_o
);

  logic instr_valid;
  logic forced_nop;
  logic alu_ready;
  logic ex_load;

  //////////////////////////////////////////////////
  // Stage valid and ready
  //////////////////////////////////////////////////

  // Valid in EX and neither halted nor killed
  assign instr_valid = id_ex_i.instr_valid && !ctrl_i.halt_ex && !ctrl_i.kill_ex;

  // Illegal from decode, passes as a no-op
  assign forced_nop = id_ex_i.illegal_insn && id_ex_i.instr_valid;

  // ALU is single cycle, so it only waits on write-back
  assign alu_ready = wb_ready_i;

  assign ex_valid_o = instr_valid &&
                      (id_ex_i.alu_en                  ||
                       (id_ex_i.mul_en && mul_valid_i) ||
                       forced_nop);

  // Kill empties the stage at once
  assign ex_ready_o = ctrl_i.kill_ex ||
                      (alu_ready && mul_ready_i && !ctrl_i.halt_ex);

  assign ex_load = ex_valid_o && wb_ready_i;

  //////////////////////////////////////////////////
  // Forwarding and branch
  //////////////////////////////////////////////////

  // Forwarded to decode, write enable is checked there
  assign rf_wdata_o = id_ex_i.mul_en ? mul_result_i : alu_res_i.result;

  assign branch_decision_o = alu_res_i.cmp_result;

  //////////////////////////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ex_wb_o <= '0;
    end else if (ex_load) begin
      ex_wb_o.instr_valid  <= 1'b1;
      ex_wb_o.pc           <= id_ex_i.pc;
      ex_wb_o.illegal_insn <= id_ex_i.illegal_insn;
      // No register write for an illegal instruction
      ex_wb_o.rf_we        <= id_ex_i.illegal_insn ? 1'b0 : id_ex_i.rf_we;

      // Destination only moves when it is written
      if (id_ex_i.rf_we) begin
        ex_wb_o.rf_waddr <= id_ex_i.rf_waddr;
        ex_wb_o.rf_wdata <= rf_wdata_o;
      end

      // Jump and branch count only for ALU instructions
      ex_wb_o.alu_jmp_qual       <= id_ex_i.alu_jmp && id_ex_i.alu_en;
      ex_wb_o.alu_bch_qual       <= id_ex_i.alu_bch && id_ex_i.alu_en;
      ex_wb_o.alu_bch_taken_qual <= id_ex_i.alu_bch && id_ex_i.alu_en &&
                                    branch_decision_o;
    end else if (wb_ready_i) begin
      // WB ready but nothing to hand over, insert a bubble
      ex_wb_o.instr_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* ex_stage.sv */
/*
 * Execute stage top
 * ALU and iterative multiplier side by side, combined into EX/WB
 */

`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  id_ex_pipe_t id_ex_i,
  input  ctrl_ex_t    ctrl_i,
  input  logic        wb_ready_i,
  output logic        ex_ready_o,
  output logic        ex_valid_o,
  output logic        branch_decision_o,
  output xlen_t       branch_target_o,
  output xlen_t       rf_wdata_o,
  output ex_wb_pipe_t ex_wb_o
);

  alu_res_t alu_res;
  xlen_t    mul_result;
  logic     mul_start;
  logic     mul_valid;
  logic     mul_ready;

  // Raw valid so a halted multiply keeps its state
  assign mul_start = id_ex_i.mul_en && id_ex_i.instr_valid;

  // Target goes straight to fetch
  assign branch_target_o = id_ex_i.operand_c;

  //////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////

  ex_alu alu_i (
    .alu_op_i    (id_ex_i.alu_op),
    .operand_a_i (id_ex_i.alu_operand_a),
    .operand_b_i (id_ex_i.alu_operand_b),
    .res_o       (alu_res)
  );

  ex_mult mult_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .mul_op_i      (id_ex_i.mul_op),
    .signed_mode_i (id_ex_i.mul_signed_mode),
    .op_a_i        (id_ex_i.muldiv_operand_a),
    .op_b_i        (id_ex_i.muldiv_operand_b),
    .halt_i        (ctrl_i.halt_ex),
    .kill_i        (ctrl_i.kill_ex),
    .valid_i       (mul_start),
    .ready_i       (wb_ready_i),
    .valid_o       (mul_valid),
    .ready_o       (mul_ready),
    .result_o      (mul_result)
  );

  // Result select, handshake and EX/WB register
  ex_wb_combine combine_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_i           (id_ex_i),
    .ctrl_i            (ctrl_i),
    .alu_res_i         (alu_res),
    .mul_result_i      (mul_result),
    .mul_valid_i       (mul_valid),
    .mul_ready_i       (mul_ready),
    .wb_ready_i        (wb_ready_i),
    .rf_wdata_o        (rf_wdata_o),
    .branch_decision_o (branch_decision_o),
    .ex_valid_o        (ex_valid_o),
    .ex_ready_o        (ex_ready_o),
    .ex_wb_o           (ex_wb_o)
  );

endmodule

`default_nettype wire

/* tb_ex_stage.sv */
/*
 * Execute stage testbench
 * Applies a table of ALU, multiply, illegal, halt, stall and kill entries
 */

`default_nettype none

`include "ex_defines.svh"

module tb_ex_stage import ex_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 100;
  // Kill arrives once the product is ready to write back
  localparam int KILL_CYCLE = `EX_MUL_STEPS;
  localparam int WB_WAIT    = 4;

  // One table row: instruction, stall controls and expected write-back
  typedef struct packed {
    id_ex_pipe_t instr;
    logic [7:0]  halt_cycles;
    logic        kill;
    logic [7:0]  stall_cycles;
    xlen_t       exp_wdata;
    logic        exp_we;
    logic        exp_illegal;
    logic        exp_taken;
  } stim_t;

  logic        clk;
  logic        rst_n;
  id_ex_pipe_t id_ex;
  ctrl_ex_t    ctrl;
  logic        wb_ready;
  logic        ex_ready;
  logic        ex_valid;
  logic        branch_decision;
  xlen_t       branch_target;
  xlen_t       rf_wdata;
  ex_wb_pipe_t ex_wb;

  stim_t stim_q[$];
  bit    table_ready;
  int    seed;
  int    errors;
  int    checks;
  int    cur_entry;
  xlen_t pc_next;

  ex_stage ex_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_i           (id_ex),
    .ctrl_i            (ctrl),
    .wb_ready_i        (wb_ready),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid),
    .branch_decision_o (branch_decision),
    .branch_target_o   (branch_target),
    .rf_wdata_o        (rf_wdata),
    .ex_wb_o           (ex_wb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference models from the RISC-V definitions
  //////////////////////////////////////////////////

  function automatic xlen_t alu_model(alu_op_e op, xlen_t a, xlen_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      // Logical shift, then fill the vacated bits with the sign
      ALU_SRA:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
      ALU_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:  return 32'h0;
    endcase
  endfunction

  function automatic logic branch_model(alu_op_e op, xlen_t a, xlen_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return sa < sb;
      ALU_GE:  return sa >= sb;
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Exact 64-bit product of the extended operands
  function automatic xlen_t mul_model(mul_op_e op, logic [1:0] sm, xlen_t a, xlen_t b);
    logic [63:0] wa;
    logic [63:0] wb;
    logic [63:0] prod;
    wa   = sm[1] ? {{32{a[31]}}, a} : {32'h0, a};
    wb   = sm[0] ? {{32{b[31]}}, b} : {32'h0, b};
    prod = wa * wb;
    return (op == MUL_H) ? prod[63:32] : prod[31:0];
  endfunction

  function automatic xlen_t rand_word();
    return xlen_t'($random(seed));
  endfunction

  //////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////

  task automatic push_alu(alu_op_e op, xlen_t a, xlen_t b, int halt_n, int stall_n);
    stim_t s;
    logic  is_bch;
    s      = '0;
    is_bch = op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    s.instr.instr_valid   = 1'b1;
    s.instr.pc            = pc_next;
    s.instr.alu_en        = 1'b1;
    s.instr.alu_op        = op;
    s.instr.alu_operand_a = a;
    s.instr.alu_operand_b = b;
    s.instr.operand_c     = rand_word();
    s.instr.alu_bch       = is_bch;
    // Branches write no register
    s.instr.rf_we         = !is_bch;
    s.instr.rf_waddr      = rf_addr_t'($random(seed));
    s.halt_cycles         = 8'(halt_n);
    s.stall_cycles        = 8'(stall_n);
    s.exp_wdata           = alu_model(op, a, b);
    s.exp_we              = !is_bch;
    s.exp_taken           = is_bch && branch_model(op, a, b);
    pc_next += 32'd4;
    stim_q.push_back(s);
  endtask

  task automatic push_mul(mul_op_e op, logic [1:0] sm, xlen_t a, xlen_t b, int halt_n,
                          int stall_n, logic kill);
    stim_t s;
    s = '0;
    s.instr.instr_valid      = 1'b1;
    s.instr.pc               = pc_next;
    s.instr.mul_en           = 1'b1;
    s.instr.mul_op           = op;
    s.instr.mul_signed_mode  = sm;
    s.instr.muldiv_operand_a = a;
    s.instr.muldiv_operand_b = b;
    s.instr.rf_we            = 1'b1;
    s.instr.rf_waddr         = rf_addr_t'($random(seed));
    s.halt_cycles            = 8'(halt_n);
    s.stall_cycles           = 8'(stall_n);
    s.kill                   = kill;
    s.exp_wdata              = mul_model(op, sm, a, b);
    s.exp_we                 = 1'b1;
    pc_next += 32'd4;
    stim_q.push_back(s);
  endtask

  task automatic build_table();
    int    i;
    xlen_t x;
    stim_t s;
    // Every ALU operator on random operands
    for (i = 0; i < 16; i++) begin
      push_alu(alu_op_e'(4'(i)), rand_word(), rand_word(), 0, 0);
    end
    x = rand_word();
    push_alu(ALU_EQ, x, x, 0, 0);
    push_alu(ALU_GEU, x, x, 0, 0);
    push_alu(ALU_SRA, rand_word() | 32'h8000_0000, rand_word(), 0, 0);
    push_alu(ALU_SLT, 32'h8000_0000, 32'h7fff_ffff, 0, 0);
    // Jump writing its link address
    s = '0;
    s.instr.instr_valid   = 1'b1;
    s.instr.pc            = pc_next;
    s.instr.alu_en        = 1'b1;
    s.instr.alu_op        = ALU_ADD;
    s.instr.alu_operand_a = pc_next;
    s.instr.alu_operand_b = 32'd4;
    s.instr.operand_c     = rand_word();
    s.instr.alu_jmp       = 1'b1;
    s.instr.rf_we         = 1'b1;
    s.instr.rf_waddr      = 5'd1;
    s.exp_wdata           = pc_next + 32'd4;
    s.exp_we              = 1'b1;
    pc_next += 32'd4;
    stim_q.push_back(s);
    // Random operands, then both forced negative
    for (i = 0; i < 2; i++) begin
      x = (i == 1) ? 32'h8000_0000 : 32'h0;
      push_mul(MUL_M32, 2'b11, rand_word() | x, rand_word() | x, 0, 0, 1'b0);
      push_mul(MUL_H, 2'b11, rand_word() | x, rand_word() | x, 0, 0, 1'b0);
      push_mul(MUL_H, 2'b10, rand_word() | x, rand_word() | x, 0, 0, 1'b0);
      push_mul(MUL_H, 2'b00, rand_word() | x, rand_word() | x, 0, 0, 1'b0);
    end
    // Most negative word and all-ones corners
    push_mul(MUL_H, 2'b11, 32'h8000_0000, 32'h8000_0000, 0, 0, 1'b0);
    push_mul(MUL_H, 2'b11, 32'h8000_0000, 32'hffff_ffff, 0, 0, 1'b0);
    push_mul(MUL_H, 2'b10, 32'h8000_0000, 32'hffff_ffff, 0, 0, 1'b0);
    push_mul(MUL_H, 2'b00, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 1'b0);
    push_mul(MUL_M32, 2'b11, 32'h8000_0000, 32'hffff_ffff, 0, 0, 1'b0);
    // Illegal instruction with a write request from decode
    s = '0;
    s.instr.instr_valid  = 1'b1;
    s.instr.pc           = pc_next;
    s.instr.illegal_insn = 1'b1;
    s.instr.rf_we        = 1'b1;
    s.instr.rf_waddr     = 5'd7;
    s.exp_illegal        = 1'b1;
    pc_next += 32'd4;
    stim_q.push_back(s);
    // Halt and back-pressure
    push_mul(MUL_H, 2'b11, rand_word(), rand_word(), 3, 0, 1'b0);
    push_mul(MUL_H, 2'b10, rand_word(), rand_word(), 0, 7, 1'b0);
    push_mul(MUL_M32, 2'b00, rand_word(), rand_word(), 2, 6, 1'b0);
    push_alu(ALU_ADD, rand_word(), rand_word(), 0, 3);
    push_alu(ALU_XOR, rand_word(), rand_word(), 2, 0);
    // Killed multiply, then an ALU op must still complete
    push_mul(MUL_H, 2'b11, rand_word(), rand_word(), 0, 0, 1'b1);
    push_alu(ALU_SUB, rand_word(), rand_word(), 0, 0);
  endtask

  //////////////////////////////////////////////////
  // Checks and entry sequencing
  //////////////////////////////////////////////////

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%08h expected 0x%08h (entry %0d)", name, got, exp,
               cur_entry);
      errors++;
    end
  endtask

  task automatic apply_entry(input int idx);
    stim_t       e;
    int          c;
    int          k;
    int          wait_n;
    int          halt_start;
    logic        accepted;
    logic        stalled;
    ex_wb_pipe_t wb_prev;
    e          = stim_q[idx];
    cur_entry  = idx;
    c          = 0;
    accepted   = 1'b0;
    stalled    = 1'b0;
    wb_prev    = ex_wb;
    // Multiply halts land mid-accumulate
    halt_start = e.instr.mul_en ? 2 : 0;
    while (!accepted) begin
      @(negedge clk);
      if (stalled) begin
        checks++;
        assert (ex_wb === wb_prev) else begin
          $display("MISMATCH ex_wb_o under back-pressure: got 0x%h expected 0x%h (entry %0d)",
                   ex_wb, wb_prev, idx);
          errors++;
        end
      end
      id_ex        = e.instr;
      ctrl.halt_ex = (c >= halt_start) && (c < halt_start + int'(e.halt_cycles));
      ctrl.kill_ex = e.kill && (c == KILL_CYCLE);
      wb_ready     = (c >= int'(e.stall_cycles));
      stalled      = !wb_ready;
      wb_prev      = ex_wb;
      // Combinational outputs settle well before the edge
      #(CLK_PERIOD/2 - 10);
      if (e.instr.alu_bch || e.instr.alu_jmp) begin
        check_value("branch_target_o", branch_target, e.instr.operand_c);
      end
      if (e.instr.alu_bch) begin
        check_value("branch_decision_o", 32'(branch_decision), 32'(e.exp_taken));
      end
      // Forwarded data is meaningful once the result is valid
      if (ex_valid && e.exp_we) begin
        check_value("rf_wdata_o", rf_wdata, e.exp_wdata);
      end
      accepted = ex_ready;
      if (accepted) begin
        check_value("ex_valid_o", 32'(ex_valid), 32'(!e.kill));
      end
      @(posedge clk);
      c++;
    end
    @(negedge clk);
    id_ex    = '0;
    ctrl     = '0;
    wb_ready = 1'b1;
    if (e.kill) begin
      for (k = 0; k < `EX_MUL_STEPS + 3; k++) begin
        checks++;
        assert (!ex_wb.instr_valid) else begin
          $display("ERROR: killed entry %0d reached write-back", idx);
          errors++;
        end
        @(negedge clk);
      end
    end else begin
      wait_n = 0;
      while (!ex_wb.instr_valid && wait_n < WB_WAIT) begin
        @(negedge clk);
        wait_n++;
      end
      checks++;
      assert (ex_wb.instr_valid) else begin
        $display("ERROR: entry %0d never reached write-back", idx);
        errors++;
      end
      if (e.halt_cycles == 0 && e.stall_cycles == 0) begin
        check_value("cycles to ex_ready_o", 32'(c), e.instr.mul_en ? `EX_MUL_STEPS + 1 : 1);
      end
      check_value("ex_wb_o.pc", ex_wb.pc, e.instr.pc);
      check_value("ex_wb_o.rf_we", 32'(ex_wb.rf_we), 32'(e.exp_we));
      check_value("ex_wb_o.illegal_insn", 32'(ex_wb.illegal_insn), 32'(e.exp_illegal));
      check_value("ex_wb_o.alu_jmp_qual", 32'(ex_wb.alu_jmp_qual), 32'(e.instr.alu_jmp));
      check_value("ex_wb_o.alu_bch_qual", 32'(ex_wb.alu_bch_qual), 32'(e.instr.alu_bch));
      check_value("ex_wb_o.alu_bch_taken_qual", 32'(ex_wb.alu_bch_taken_qual),
                  32'(e.exp_taken));
      if (e.exp_we) begin
        check_value("ex_wb_o.rf_waddr", 32'(ex_wb.rf_waddr), 32'(e.instr.rf_waddr));
        check_value("ex_wb_o.rf_wdata", ex_wb.rf_wdata, e.exp_wdata);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin : main_seq
    int i;
    seed      = 32'h00e0a369;
    errors    = 0;
    checks    = 0;
    cur_entry = -1;
    pc_next   = 32'h0000_1000;
    rst_n     = 1'b0;
    id_ex     = '0;
    ctrl      = '0;
    wb_ready  = 1'b1;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Clean state out of reset
    check_value("ex_wb_o.instr_valid", 32'(ex_wb.instr_valid), 32'h0);
    check_value("ex_wb_o.rf_we", 32'(ex_wb.rf_we), 32'h0);
    check_value("ex_valid_o", 32'(ex_valid), 32'h0);
    for (i = 0; i < stim_q.size(); i++) begin
      apply_entry(i);
    end
    $display("Summary: %0d entries, %0d checks, %0d errors", stim_q.size(), checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    int j;
    int max_halt;
    int max_stall;
    int limit;
    wait (table_ready);
    max_halt  = 0;
    max_stall = 0;
    for (j = 0; j < stim_q.size(); j++) begin
      if (int'(stim_q[j].halt_cycles) > max_halt) max_halt = int'(stim_q[j].halt_cycles);
      if (int'(stim_q[j].stall_cycles) > max_stall) max_stall = int'(stim_q[j].stall_cycles);
    end
    limit = stim_q.size() * (`EX_MUL_STEPS + max_halt + max_stall + 4) + 40;
    repeat (limit) @(posedge clk);
    $display("ERROR: run did not finish within %0d clock cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_wb_combine.sv
ex_stage.sv
tb_ex_stage.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_stage \
  -f build.f -o sim_ex_stage
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi

exit 0
